/* Bender.yml */
package:
  name: present_core

sources:
  - files:
      - hdl/present_pkg.sv
      - hdl/present_round_key_ram.sv
      - hdl/present_key_schedule.sv
      - hdl/present_round_datapath.sv
      - hdl/present_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/present_core_tb.sv

/* hdl/present_core.sv */
`timescale 1ns/10ps

module present_core #(
    parameter int NUM_ROUNDS = 31
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             key_valid_i,
    input  logic [present_pkg::KEY_W-1:0]    key_i,
    output logic                             key_ready_o,
    input  logic                             in_valid_i,
    input  logic [present_pkg::BLOCK_W-1:0]  in_block_i,
    input  logic                             in_decrypt_i,
    output logic                             in_ready_o,
    output logic                             out_valid_o,
    output logic [present_pkg::BLOCK_W-1:0]  out_block_o,
    input  logic                             out_ready_i
);

    logic key_start;
    logic blk_start;
    logic keys_ready;
    logic dp_busy;
    logic dp_done;
    logic wr_en;
    logic [present_pkg::ROUND_IDX_W-1:0] wr_addr;
    logic [present_pkg::ROUND_IDX_W-1:0] rd_addr;
    logic [present_pkg::RKEY_W-1:0] wr_data;
    logic [present_pkg::RKEY_W-1:0] rd_data;
    logic [present_pkg::BLOCK_W-1:0] dp_result;

    // The key store may only be rewritten while no block is using it
    assign key_ready_o = !dp_busy && !out_valid_o;
    assign key_start = key_valid_i && key_ready_o;

    // A key offered in the same cycle wins over a block
    assign in_ready_o = keys_ready && !dp_busy && !out_valid_o && !key_valid_i;
    assign blk_start = in_valid_i && in_ready_o;

    present_key_schedule #(
        .NUM_ROUNDS(NUM_ROUNDS)
    ) key_schedule_i (
        .clk(clk),
        .rst(rst),
        .start_i(key_start),
        .key_i(key_i),
        .wr_en_o(wr_en),
        .wr_addr_o(wr_addr),
        .wr_data_o(wr_data),
        .keys_ready_o(keys_ready)
    );

    present_round_key_ram #(
        .NUM_ROUNDS(NUM_ROUNDS)
    ) round_key_ram_i (
        .clk(clk),
        .rst(rst),
        .wr_en_i(wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data)
    );

    present_round_datapath #(
        .NUM_ROUNDS(NUM_ROUNDS)
    ) round_datapath_i (
        .clk(clk),
        .rst(rst),
        .start_i(blk_start),
        .decrypt_i(in_decrypt_i),
        .block_i(in_block_i),
        .rd_data_i(rd_data),
        .rd_addr_o(rd_addr),
        .busy_o(dp_busy),
        .done_o(dp_done),
        .result_o(dp_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
        end else if (dp_done) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // Holds until the consumer takes it
    always_ff @(posedge clk) begin
        if (dp_done) begin
            out_block_o <= dp_result;
        end
    end

endmodule

/* hdl/present_key_schedule.sv */
`timescale 1ns/10ps

module present_key_schedule #(
    parameter int NUM_ROUNDS = 31
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start_i,
    input  logic [present_pkg::KEY_W-1:0]        key_i,
    output logic                                 wr_en_o,
    output logic [present_pkg::ROUND_IDX_W-1:0]  wr_addr_o,
    output logic [present_pkg::RKEY_W-1:0]       wr_data_o,
    output logic                                 keys_ready_o
);

    localparam int IDX_W = present_pkg::ROUND_IDX_W;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_ROUNDS);

    typedef enum logic [1:0] {
        IDLE,
        STORE,
        DONE
    } state_t;

    state_t state_q;

    logic [present_pkg::KEY_W-1:0] key_q;

    // Store address of the key in the key register, one below its round number
    logic [IDX_W-1:0] idx_q;
    logic [IDX_W-1:0] round_idx;

    assign round_idx = idx_q + 1'b1;

    // The write port is registered, so the last key lands one cycle after DONE is entered
    assign keys_ready_o = (state_q == DONE) && !wr_en_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            idx_q <= '0;
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;
            if (start_i) begin
                state_q <= STORE;
                idx_q <= '0;
            end else if (state_q == STORE) begin
                wr_en_o <= 1'b1;
                idx_q <= round_idx;
                if (idx_q == LAST_IDX) begin
                    state_q <= DONE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            key_q <= key_i;
        end else if (state_q == STORE) begin
            key_q <= present_pkg::key_update(key_q, round_idx);
        end
        if (state_q == STORE) begin
            wr_addr_o <= idx_q;
            // Round key is the top 64 bits of the key register
            wr_data_o <= key_q[present_pkg::KEY_W-1 -: present_pkg::RKEY_W];
        end
    end

endmodule

/* hdl/present_pkg.sv */
package present_pkg;

    localparam int BLOCK_W = 64;
    localparam int KEY_W = 80;
    localparam int RKEY_W = 64;
    localparam int ROUND_IDX_W = 5;

    localparam logic [3:0] SBOX [16] = '{
        4'hc, 4'h5, 4'h6, 4'hb, 4'h9, 4'h0, 4'ha, 4'hd,
        4'h3, 4'he, 4'hf, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
    };

    localparam logic [3:0] SBOX_INV [16] = '{
        4'h5, 4'he, 4'hf, 4'h8, 4'hc, 4'h1, 4'h2, 4'hd,
        4'hb, 4'h4, 4'h6, 4'h3, 4'h0, 4'h7, 4'h9, 4'ha
    };

    // Bit i of the state moves to position 16*i mod 63, the top bit stays put
    function automatic int p_pos(input int i);
        return (i == BLOCK_W - 1) ? i : (i * 16) % (BLOCK_W - 1);
    endfunction

    function automatic logic [BLOCK_W-1:0] sbox_layer(input logic [BLOCK_W-1:0] s);
        logic [BLOCK_W-1:0] r;
        for (int n = 0; n < BLOCK_W / 4; n++) begin
            r[4*n +: 4] = SBOX[s[4*n +: 4]];
        end
        return r;
    endfunction

    function automatic logic [BLOCK_W-1:0] sbox_inv_layer(input logic [BLOCK_W-1:0] s);
        logic [BLOCK_W-1:0] r;
        for (int n = 0; n < BLOCK_W / 4; n++) begin
            r[4*n +: 4] = SBOX_INV[s[4*n +: 4]];
        end
        return r;
    endfunction

    function automatic logic [BLOCK_W-1:0] p_layer(input logic [BLOCK_W-1:0] s);
        logic [BLOCK_W-1:0] r;
        for (int i = 0; i < BLOCK_W; i++) begin
            r[p_pos(i)] = s[i];
        end
        return r;
    endfunction

    function automatic logic [BLOCK_W-1:0] p_inv_layer(input logic [BLOCK_W-1:0] s);
        logic [BLOCK_W-1:0] r;
        for (int i = 0; i < BLOCK_W; i++) begin
            r[i] = s[p_pos(i)];
        end
        return r;
    endfunction

    // One step of the 80-bit key register, rc is the round counter of the key just used
    function automatic logic [KEY_W-1:0] key_update(
        input logic [KEY_W-1:0] k,
        input logic [ROUND_IDX_W-1:0] rc
    );
        logic [KEY_W-1:0] r;
        r = {k[18:0], k[KEY_W-1:19]};
        r[KEY_W-1 -: 4] = SBOX[r[KEY_W-1 -: 4]];
        r[19:15] = r[19:15] ^ rc;
        return r;
    endfunction

endpackage

/* hdl/present_round_datapath.sv */
`timescale 1ns/10ps

module present_round_datapath #(
    parameter int NUM_ROUNDS = 31
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start_i,
    input  logic                                 decrypt_i,
    input  logic [present_pkg::BLOCK_W-1:0]      block_i,
    input  logic [present_pkg::RKEY_W-1:0]       rd_data_i,
    output logic [present_pkg::ROUND_IDX_W-1:0]  rd_addr_o,
    output logic                                 busy_o,
    output logic                                 done_o,
    output logic [present_pkg::BLOCK_W-1:0]      result_o
);

    localparam int IDX_W = present_pkg::ROUND_IDX_W;
    localparam logic [IDX_W-1:0] TOP_ADDR = IDX_W'(NUM_ROUNDS);

    typedef enum logic [1:0] {
        IDLE,
        PREFETCH,
        ROUND,
        FINAL
    } phase_t;

    phase_t phase_q;

    logic decrypt_q;
    logic [present_pkg::BLOCK_W-1:0] state_q;
    logic [present_pkg::BLOCK_W-1:0] mixed;
    logic [present_pkg::BLOCK_W-1:0] round_out;
    logic [IDX_W-1:0] last_addr;
    logic [IDX_W-1:0] next_addr;

    // rd_data_i always holds the key for the current round, fetched one cycle ahead
    assign mixed = state_q ^ rd_data_i;

    always_comb begin
        if (decrypt_q) begin
            round_out = present_pkg::sbox_inv_layer(present_pkg::p_inv_layer(mixed));
        end else begin
            round_out = present_pkg::p_layer(present_pkg::sbox_layer(mixed));
        end
    end

    // Encryption walks the key store upwards, decryption downwards
    assign last_addr = decrypt_q ? '0 : TOP_ADDR;
    assign next_addr = decrypt_q ? rd_addr_o - 1'b1 : rd_addr_o + 1'b1;

    assign busy_o = (phase_q != IDLE);
    assign done_o = (phase_q == FINAL);

    // Final whitening with the last key is taken straight into the output register
    assign result_o = mixed;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= IDLE;
            rd_addr_o <= '0;
        end else begin
            case (phase_q)
                IDLE: begin
                    if (start_i) begin
                        phase_q <= PREFETCH;
                        rd_addr_o <= decrypt_i ? TOP_ADDR : '0;
                    end
                end
                PREFETCH: begin
                    phase_q <= ROUND;
                    rd_addr_o <= next_addr;
                end
                ROUND: begin
                    // The address already points at the whitening key in the last round
                    if (rd_addr_o == last_addr) begin
                        phase_q <= FINAL;
                    end else begin
                        rd_addr_o <= next_addr;
                    end
                end
                FINAL: begin
                    phase_q <= IDLE;
                end
                default: begin
                    phase_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((phase_q == IDLE) && start_i) begin
            state_q <= block_i;
            decrypt_q <= decrypt_i;
        end else if (phase_q == ROUND) begin
            state_q <= round_out;
        end
    end

endmodule

/* hdl/present_round_key_ram.sv */
`timescale 1ns/10ps

module present_round_key_ram #(
    parameter int NUM_ROUNDS = 31
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wr_en_i,
    input  logic [present_pkg::ROUND_IDX_W-1:0]  wr_addr_i,
    input  logic [present_pkg::RKEY_W-1:0]       wr_data_i,
    input  logic [present_pkg::ROUND_IDX_W-1:0]  rd_addr_i,
    output logic [present_pkg::RKEY_W-1:0]       rd_data_o
);

    // Round key i lives at address i-1
    logic [present_pkg::RKEY_W-1:0] mem [NUM_ROUNDS+1];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* present_core.f */
+incdir+verif
hdl/present_pkg.sv
hdl/present_round_key_ram.sv
hdl/present_key_schedule.sv
hdl/present_round_datapath.sv
hdl/present_core.sv
verif/present_core_tb.sv

/* verif/present_ref_model.svh */
`ifndef PRESENT_REF_MODEL_SVH
`define PRESENT_REF_MODEL_SVH

// Nibble x of this constant is S(x)
localparam logic [63:0] SBOX_NIBBLES = 64'h21748fe3da09b65c;

function automatic logic [3:0] sbox_nibble(input logic [3:0] x);
    return SBOX_NIBBLES[4*x +: 4];
endfunction

function automatic logic [3:0] sbox_inverse_nibble(input logic [3:0] y);
    logic [3:0] x;
    x = 4'h0;
    for (int v = 0; v < 16; v++) begin
        if (sbox_nibble(4'(v)) == y) begin
            x = 4'(v);
        end
    end
    return x;
endfunction

function automatic logic [63:0] substitute(input logic [63:0] s, input bit inverse);
    logic [63:0] r;
    for (int n = 0; n < 16; n++) begin
        r[4*n +: 4] = inverse ? sbox_inverse_nibble(s[4*n +: 4]) : sbox_nibble(s[4*n +: 4]);
    end
    return r;
endfunction

// Bit i moves to 16*(i mod 4) + i/4
function automatic logic [63:0] permute_bits(input logic [63:0] s);
    logic [63:0] r;
    for (int i = 0; i < 64; i++) begin
        r[16 * (i % 4) + i / 4] = s[i];
    end
    return r;
endfunction

function automatic logic [63:0] unpermute_bits(input logic [63:0] s);
    logic [63:0] r;
    for (int i = 0; i < 64; i++) begin
        r[i] = s[16 * (i % 4) + i / 4];
    end
    return r;
endfunction

// Round key i, counted from 1, is the top of the key register after i-1 updates
function automatic logic [63:0] round_key_of(input logic [79:0] key, input int i);
    logic [79:0] k;
    k = key;
    for (int r = 1; r < i; r++) begin
        k = (k << 61) | (k >> 19);
        k[79:76] = sbox_nibble(k[79:76]);
        k[19:15] = k[19:15] ^ 5'(r);
    end
    return k[79:16];
endfunction

function automatic logic [63:0] encrypt_block(input logic [63:0] pt, input logic [79:0] key,
                                              input int rounds);
    logic [63:0] s;
    s = pt;
    for (int i = 1; i <= rounds; i++) begin
        s = permute_bits(substitute(s ^ round_key_of(key, i), 1'b0));
    end
    return s ^ round_key_of(key, rounds + 1);
endfunction

function automatic logic [63:0] decrypt_block(input logic [63:0] ct, input logic [79:0] key,
                                              input int rounds);
    logic [63:0] s;
    s = ct ^ round_key_of(key, rounds + 1);
    for (int i = rounds; i >= 1; i--) begin
        s = substitute(unpermute_bits(s), 1'b1) ^ round_key_of(key, i);
    end
    return s;
endfunction

`endif

/* verif/present_core_tb.sv */
`timescale 1ns/10ps

module present_core_tb;

    localparam int NUM_ROUNDS = 31;
    localparam int LATENCY = NUM_ROUNDS + 2;
    localparam int NUM_KEYS = 8;
    localparam int BLOCKS_PER_KEY = 4;
    localparam int MAX_STALL = 7;
    // Every key and every block is one transfer
    localparam int NUM_TRANSFERS = 4 + NUM_KEYS * (2 + 3 * BLOCKS_PER_KEY);
    localparam int TIMEOUT_CYCLES = NUM_TRANSFERS * (NUM_ROUNDS + 4 + MAX_STALL) + 200;

    `include "present_ref_model.svh"

    logic clk = 1'b0;
    logic rst;
    logic key_valid;
    logic [79:0] key;
    logic key_ready;
    logic in_valid;
    logic [63:0] in_block;
    logic in_decrypt;
    logic in_ready;
    logic out_valid;
    logic [63:0] out_block;
    logic out_ready;

    integer seed = 32'ha24c;
    string test_name = "reset";
    logic [63:0] exp_q [$];
    int cycle = 0;
    bit have_key = 1'b0;
    int key_cycle = 0;
    int in_cycle = 0;
    bit valid_seen = 1'b0;
    bit held = 1'b0;
    logic [63:0] held_block;
    logic [63:0] exp_block;

    present_core #(
        .NUM_ROUNDS(NUM_ROUNDS)
    ) present_core_i (
        .clk(clk),
        .rst(rst),
        .key_valid_i(key_valid),
        .key_i(key),
        .key_ready_o(key_ready),
        .in_valid_i(in_valid),
        .in_block_i(in_block),
        .in_decrypt_i(in_decrypt),
        .in_ready_o(in_ready),
        .out_valid_o(out_valid),
        .out_block_o(out_block),
        .out_ready_i(out_ready)
    );

    always #4 clk = ~clk;

    task automatic stop_run(input string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic describe_error(input string what);
        $display("%s", what);
        stop_run(what);
    endtask

    task automatic mismatch_block(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
        $display("Fail %s: expected %h actual %h", name, exp, act);
        stop_run("Result mismatch");
    endtask

    task automatic wrong_latency(input string name, input int exp, input int act);
        $display("Fail %s: expected %0d cycles actual %0d cycles", name, exp, act);
        stop_run("Latency mismatch");
    endtask

    function automatic logic [79:0] random_key();
        logic [95:0] raw;
        raw = {$random(seed), $random(seed), $random(seed)};
        return raw[79:0];
    endfunction

    task automatic load_key(input logic [79:0] k);
        key_valid = 1'b1;
        key = k;
        @(posedge clk);
        while (!key_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        key_valid = 1'b0;
    endtask

    task automatic check_key_store(input logic [79:0] k);
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        for (int i = 1; i <= NUM_ROUNDS + 1; i++) begin
            assert (present_core_i.round_key_ram_i.mem[i-1] == round_key_of(k, i)) else
                mismatch_block("round key store", round_key_of(k, i),
                               present_core_i.round_key_ram_i.mem[i-1]);
        end
        @(negedge clk);
    endtask

    // Sends one block, then takes the result after a random stall
    task automatic run_block(input logic [63:0] blk, input logic dec, input logic [63:0] exp,
                             output logic [63:0] res);
        int stall;
        exp_q.push_back(exp);
        in_valid = 1'b1;
        in_block = blk;
        in_decrypt = dec;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (!out_valid) begin
            @(negedge clk);
        end
        stall = $random(seed) & MAX_STALL;
        repeat (stall) begin
            @(negedge clk);
        end
        out_ready = 1'b1;
        res = out_block;
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst) begin
            if (in_ready) begin
                assert (have_key && (cycle - key_cycle > LATENCY)) else
                    describe_error("in_ready_o rose before key expansion had finished");
            end
            if (key_valid && key_ready) begin
                have_key = 1'b1;
                key_cycle = cycle;
            end
            if (in_valid && in_ready) begin
                in_cycle = cycle;
            end
            // out_valid_o is first seen at the edge after the one that set it
            if (out_valid && !valid_seen) begin
                assert (cycle - 1 - in_cycle == LATENCY) else
                    wrong_latency("block latency", LATENCY, cycle - 1 - in_cycle);
            end
            if (out_valid) begin
                assert (!in_ready && !key_ready) else
                    describe_error("A ready output was high while a result was pending");
                assert (exp_q.size() > 0) else
                    describe_error("out_valid_o was high with no block pending");
            end
            if (held) begin
                assert (out_valid) else
                    describe_error("out_valid_o dropped before the result was taken");
                assert (out_block == held_block) else
                    mismatch_block("back-pressure hold", held_block, out_block);
            end
            if (out_valid && out_ready) begin
                exp_block = exp_q.pop_front();
                assert (out_block == exp_block) else
                    mismatch_block(test_name, exp_block, out_block);
            end
            held = out_valid && !out_ready;
            held_block = out_block;
            valid_seen = out_valid;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        describe_error("Timeout: the tests did not finish in the expected number of cycles");
    end

    initial begin
        logic [79:0] k;
        logic [63:0] pt;
        logic [63:0] ct;
        logic [63:0] res;
        rst = 1'b1;
        key_valid = 1'b0;
        key = '0;
        in_valid = 1'b0;
        in_block = '0;
        in_decrypt = 1'b0;
        out_ready = 1'b0;
        repeat (4) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        assert (key_ready && !in_ready && !out_valid) else
            describe_error("Handshake flags are wrong after reset");
        @(negedge clk);

        test_name = "known answer zero key";
        load_key('0);
        check_key_store('0);
        run_block('0, 1'b0, 64'h5579c1387b228445, res);
        test_name = "known answer ones key";
        load_key('1);
        check_key_store('1);
        run_block('0, 1'b0, 64'he72c46c0f5945049, res);

        for (int n = 0; n < NUM_KEYS; n++) begin
            k = random_key();
            pt = {$random(seed), $random(seed)};
            test_name = "re-key";
            load_key(k);
            // This block is offered while the new key is still expanding
            if (n % 2 == 1) begin
                run_block(pt, 1'b1, decrypt_block(pt, k, NUM_ROUNDS), res);
            end else begin
                run_block(pt, 1'b0, encrypt_block(pt, k, NUM_ROUNDS), res);
            end
            check_key_store(k);
            for (int b = 0; b < BLOCKS_PER_KEY; b++) begin
                pt = {$random(seed), $random(seed)};
                test_name = "random encrypt";
                run_block(pt, 1'b0, encrypt_block(pt, k, NUM_ROUNDS), ct);
                test_name = "round trip";
                run_block(ct, 1'b1, pt, res);
                ct = {$random(seed), $random(seed)};
                test_name = "random decrypt";
                run_block(ct, 1'b1, decrypt_block(ct, k, NUM_ROUNDS), res);
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
